// File: ex_stage.f
+incdir+source
source/ex_pkg.sv
source/key_store.sv
source/ex_issue_reg.sv
source/alu_chaos.sv
source/alu.sv
source/ex_writeback_reg.sv
source/ex_stage.sv
sim/tb_clock_gen.sv
sim/tb_ex_stage.sv

// File: Bender.yml
package:
  name: ex_stage

sources:
  - include_dirs:
      - source
    files:
      - source/ex_pkg.sv
      - source/key_store.sv
      - source/ex_issue_reg.sv
      - source/alu_chaos.sv
      - source/alu.sv
      - source/ex_writeback_reg.sv
      - source/ex_stage.sv
  - target: test
    include_dirs:
      - source
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_ex_stage.sv

// File: sim/tb_ex_stage.sv
`timescale 1ns/1ps
`include "ex_config.svh"

module tb_ex_stage import ex_pkg::*; ();

  logic      clk;
  logic      rst_n;
  logic      key_load;
  key_word_t key_word;
  logic      issue_valid;
  data_t     op_a;
  data_t     op_b;
  data_t     pc;
  alu_op_e   alu_op;
  logic      is_lui;
  logic      is_auipc;
  logic      is_jal;
  logic      is_jalr;
  logic      is_compare;
  reg_idx_t  rd;
  logic      wb_valid;
  data_t     wb_data;
  logic      wb_comp;
  reg_idx_t  wb_rd;
  logic      wb_we;

  // Expected items, oldest first
  data_t     exp_data[$];
  logic      exp_comp[$];
  reg_idx_t  exp_rd[$];
  logic      exp_we[$];
  data_t     e_data;
  logic      e_comp;
  reg_idx_t  e_rd;
  logic      e_we;

  // Plain ALU results of the random key items, in issue order
  data_t     plain_q[$];

  // Key as the model sees it, built by the same shift rule
  key_t      model_key;
  logic [31:0] rng_state;
  int        data_errors;
  int        protocol_errors;
  int        timeout_errors;
  int        diff_count;

  tb_clock_gen i_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  ex_stage i_dut (
    .clk(clk), .rst_n(rst_n), .key_load(key_load), .key_word(key_word),
    .issue_valid(issue_valid), .op_a(op_a), .op_b(op_b), .pc(pc), .alu_op(alu_op),
    .is_lui(is_lui), .is_auipc(is_auipc), .is_jal(is_jal), .is_jalr(is_jalr),
    .is_compare(is_compare), .rd(rd), .wb_valid(wb_valid), .wb_data(wb_data),
    .wb_comp(wb_comp), .wb_rd(wb_rd), .wb_we(wb_we)
  );

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Plain RV32 ALU, no key involved
  function automatic data_t plain_alu(data_t a, data_t b, alu_op_e op);
    case (op)
      op_add:  return a + b;
      op_sub:  return a - b;
      op_and:  return a & b;
      op_or:   return a | b;
      op_xor:  return a ^ b;
      op_sll:  return a << b[4:0];
      op_srl:  return a >> b[4:0];
      default: return $signed(a) >>> b[4:0];
    endcase
  endfunction

  function automatic data_t rotl(data_t x, logic [4:0] r);
    return (r == 0) ? x : ((x << r) | (x >> (6'd32 - r)));
  endfunction

  // Remap via field n, mask b, rotate, mask result
  function automatic data_t keyed_result(data_t a, data_t b, alu_op_e op, key_t k);
    alu_op_e real_op;
    data_t   bm;
    real_op = alu_op_e'(k[3*op +: 3]);
    bm = b ^ k[63:32];
    return rotl(plain_alu(a, bm, real_op), k[28:24]) ^ k[95:64];
  endfunction

  // Flags ordered lui, auipc, jal, jalr, compare from bit 4 down
  function automatic data_t expected_result(data_t a, data_t b, data_t p, alu_op_e op,
                                            logic [4:0] fl, key_t k);
    if (fl[4]) return b;
    if (fl[3]) return b + {20'b0, p[11:0]};
    if (fl[2]) return p + 32'd4;
    if (fl[1]) return p;
    if (fl[0] && (a < b)) return 32'd1;
    return keyed_result(a, b, op, k);
  endfunction

  function automatic key_t correct_key();
    key_t k;
    k = '0;
    for (int n = 0; n < 8; n++) k[3*n +: 3] = 3'(n);
    return k;
  endfunction

  ////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////

  task automatic issue(input data_t a, input data_t b, input data_t p, input alu_op_e op,
                       input logic [4:0] fl, input reg_idx_t dst, input data_t exp);
    @(posedge clk);
    issue_valid <= 1'b1;
    op_a        <= a;
    op_b        <= b;
    pc          <= p;
    alu_op      <= op;
    {is_lui, is_auipc, is_jal, is_jalr, is_compare} <= fl;
    rd          <= dst;
    exp_data.push_back(exp);
    exp_comp.push_back(a < b);
    exp_rd.push_back(dst);
    exp_we.push_back(dst != 5'd0);
  endtask

  task automatic stop_issue();
    @(posedge clk);
    issue_valid <= 1'b0;
  endtask

  // Wait on falling edges so the checker has popped first
  task automatic drain(input string what);
    int n;
    for (n = 0; n < 20 && exp_data.size() != 0; n++) @(negedge clk);
    if (exp_data.size() != 0) begin
      $display("Timeout at %0t: writeback of the %s did not complete", $time, what);
      timeout_errors++;
      exp_data.delete();
      exp_comp.delete();
      exp_rd.delete();
      exp_we.delete();
      plain_q.delete();
    end
  endtask

  // First word ends up in the top key word
  task automatic load_key(input key_t k);
    for (int i = 0; i < `EX_KEY_WORDS; i++) begin
      @(posedge clk);
      key_load  <= 1'b1;
      key_word  <= k[`EX_KEY_W-1-32*i -: 32];
      model_key = {model_key[`EX_KEY_W-33:0], k[`EX_KEY_W-1-32*i -: 32]};
    end
    @(posedge clk);
    key_load <= 1'b0;
  endtask

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Outputs sampled at the edge hold last cycle's values
  always @(posedge clk) begin
    if (rst_n && wb_valid) begin
      if (exp_data.size() == 0) begin
        $display("wb_valid rose at %0t with no item in flight", $time);
        protocol_errors++;
      end else begin
        e_data = exp_data.pop_front();
        e_comp = exp_comp.pop_front();
        e_rd   = exp_rd.pop_front();
        e_we   = exp_we.pop_front();
        assert (wb_data == e_data) else begin
          $display("Mismatch at %0t: wb_data expected %h got %h", $time, e_data, wb_data);
          data_errors++;
        end
        assert (wb_comp == e_comp) else begin
          $display("Mismatch at %0t: wb_comp expected %b got %b", $time, e_comp, wb_comp);
          data_errors++;
        end
        assert (wb_rd == e_rd) else begin
          $display("Mismatch at %0t: wb_rd expected %0d got %0d", $time, e_rd, wb_rd);
          data_errors++;
        end
        assert (wb_we == e_we) else begin
          $display("Mismatch at %0t: wb_we expected %b got %b", $time, e_we, wb_we);
          data_errors++;
        end
        // Random key items against what a plain ALU would give
        if (plain_q.size() != 0) begin
          if (wb_data != plain_q.pop_front()) begin
            diff_count++;
          end
        end
      end
    end
  end

  latency_check: assert property (@(posedge clk) disable iff (!rst_n)
    issue_valid |-> ##(`EX_LATENCY) wb_valid)
    else begin
      $display("Writeback did not follow an issue by %0d cycles at %0t", `EX_LATENCY, $time);
      protocol_errors++;
    end

  // Also keeps wb_valid low until the first issue
  origin_check: assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid |-> $past(issue_valid, `EX_LATENCY))
    else begin
      $display("Writeback valid at %0t without a matching issue", $time);
      protocol_errors++;
    end

  reset_check: assert property (@(posedge clk) !rst_n |=> (!wb_valid && !wb_we))
    else begin
      $display("Writeback valid or write enable high around reset at %0t", $time);
      protocol_errors++;
    end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    data_t      a;
    data_t      b;
    data_t      p;
    data_t      exp;
    alu_op_e    op;
    logic [4:0] fl;
    int         n;
    rng_state       = 32'h6b0f_721a;
    model_key       = '0;
    data_errors     = 0;
    protocol_errors = 0;
    timeout_errors  = 0;
    diff_count      = 0;
    key_load    = 1'b0;
    key_word    = '0;
    issue_valid = 1'b0;
    op_a        = '0;
    op_b        = '0;
    pc          = '0;
    alu_op      = op_add;
    {is_lui, is_auipc, is_jal, is_jalr, is_compare} = 5'b0;
    rd          = '0;

    for (n = 0; n < 20 && rst_n !== 1'b1; n++) @(posedge clk);
    if (rst_n !== 1'b1) begin
      $display("Timeout at %0t: reset was never released", $time);
      timeout_errors++;
    end
    // Idle a while, nothing may come out
    repeat (4) @(posedge clk);

    // Zero key after reset, every op is a plain add
    for (int i = 0; i < 8; i++) begin
      a = next_rand();
      b = next_rand();
      issue(a, b, next_rand(), alu_op_e'(i), 5'b0, reg_idx_t'(i + 1), a + b);
    end
    stop_issue();
    drain("reset key batch");

    // Correct key, back to back, random rd including x0
    load_key(correct_key());
    for (int i = 0; i < 32; i++) begin
      a  = next_rand();
      b  = next_rand();
      op = alu_op_e'(i % 8);
      issue(a, b, next_rand(), op, 5'b0, reg_idx_t'(next_rand()), plain_alu(a, b, op));
    end
    stop_issue();
    drain("correct key batch");

    // Random key
    load_key({next_rand(), next_rand(), next_rand()});
    for (int i = 0; i < 32; i++) begin
      a   = next_rand();
      b   = next_rand();
      op  = alu_op_e'(next_rand() % 8);
      exp = keyed_result(a, b, op, model_key);
      issue(a, b, next_rand(), op, 5'b0, reg_idx_t'(i + 1), exp);
      plain_q.push_back(plain_alu(a, b, op));
    end
    stop_issue();
    drain("random key batch");
    assert (diff_count > 0) else begin
      $display("Random key gave the same results as the plain ALU");
      data_errors++;
    end

    // Special cases, flags singly then in pairs
    for (int i = 0; i < 5; i++) begin
      for (int j = i; j < 5; j++) begin
        a  = next_rand();
        b  = next_rand();
        p  = next_rand();
        op = alu_op_e'(next_rand() % 8);
        fl = (5'b1 << i) | (5'b1 << j);
        issue(a, b, p, op, fl, reg_idx_t'(j + 3), expected_result(a, b, p, op, fl, model_key));
      end
    end
    // Compare true and false
    issue(32'd5, 32'd9, 32'h100, op_xor, 5'b00001, 5'd7,
          expected_result(32'd5, 32'd9, 32'h100, op_xor, 5'b00001, model_key));
    issue(32'd9, 32'd5, 32'h104, op_xor, 5'b00001, 5'd7,
          expected_result(32'd9, 32'd5, 32'h104, op_xor, 5'b00001, model_key));
    stop_issue();
    drain("special case batch");

    // x0 against nonzero destinations, with gaps between issues
    for (int i = 0; i < 6; i++) begin
      a  = next_rand();
      b  = next_rand();
      issue(a, b, next_rand(), op_add, 5'b0, (i % 2 == 0) ? 5'd0 : 5'd31,
            keyed_result(a, b, op_add, model_key));
      stop_issue();
    end
    drain("destination batch");

    repeat (4) @(posedge clk);
    $display("Errors: data %0d, protocol %0d, timeout %0d",
             data_errors, protocol_errors, timeout_errors);
    if (data_errors + protocol_errors + timeout_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule : tb_ex_stage

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int half_period  = 20,
  parameter int reset_cycles = 3
) (
  output logic clk,
  output logic rst_n
);

  // Free running clock, 40 ns period
  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  // Reset low from time zero, released on a rising edge
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule : tb_clock_gen

// File: source/ex_stage.sv
`timescale 1ns/1ps

module ex_stage import ex_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  // Key load
  input  logic      key_load,
  input  key_word_t key_word,
  // Issue
  input  logic      issue_valid,
  input  data_t     op_a,
  input  data_t     op_b,
  input  data_t     pc,
  input  alu_op_e   alu_op,
  input  logic      is_lui,
  input  logic      is_auipc,
  input  logic      is_jal,
  input  logic      is_jalr,
  input  logic      is_compare,
  input  reg_idx_t  rd,
  // Writeback
  output logic      wb_valid,
  output data_t     wb_data,
  output logic      wb_comp,
  output reg_idx_t  wb_rd,
  output logic      wb_we
);

  key_t     key;

  // Issue register outputs
  logic     exec_valid;
  data_t    exec_a;
  data_t    exec_b;
  data_t    exec_pc;
  alu_op_e  exec_op;
  logic     exec_lui;
  logic     exec_auipc;
  logic     exec_jal;
  logic     exec_jalr;
  logic     exec_compare;
  reg_idx_t exec_rd;

  // ALU outputs
  data_t    res;
  logic     comp_res;

  ////////////////////////////////////////
  // Key path
  ////////////////////////////////////////

  key_store i_key_store (
    .clk      (clk),
    .rst_n    (rst_n),
    .key_load (key_load),
    .key_word (key_word),
    .key      (key)
  );

  ////////////////////////////////////////
  // Issue to execute
  ////////////////////////////////////////

  ex_issue_reg i_ex_issue_reg (
    .clk          (clk),
    .rst_n        (rst_n),
    .issue_valid  (issue_valid),
    .op_a         (op_a),
    .op_b         (op_b),
    .pc           (pc),
    .alu_op       (alu_op),
    .is_lui       (is_lui),
    .is_auipc     (is_auipc),
    .is_jal       (is_jal),
    .is_jalr      (is_jalr),
    .is_compare   (is_compare),
    .rd           (rd),
    .exec_valid   (exec_valid),
    .exec_a       (exec_a),
    .exec_b       (exec_b),
    .exec_pc      (exec_pc),
    .exec_op      (exec_op),
    .exec_lui     (exec_lui),
    .exec_auipc   (exec_auipc),
    .exec_jal     (exec_jal),
    .exec_jalr    (exec_jalr),
    .exec_compare (exec_compare),
    .exec_rd      (exec_rd)
  );

  // Combinational on the registered issue values
  alu i_alu (
    .a          (exec_a),
    .b          (exec_b),
    .pres_adr   (exec_pc),
    .alusel     (exec_op),
    .is_lui     (exec_lui),
    .is_auipc   (exec_auipc),
    .is_jal     (exec_jal),
    .is_jalr    (exec_jalr),
    .is_compare (exec_compare),
    .key        (key),
    .res        (res),
    .comp_res   (comp_res)
  );

  ////////////////////////////////////////
  // Execute to writeback
  ////////////////////////////////////////

  ex_writeback_reg i_ex_writeback_reg (
    .clk        (clk),
    .rst_n      (rst_n),
    .exec_valid (exec_valid),
    .res        (res),
    .comp_res   (comp_res),
    .exec_rd    (exec_rd),
    .wb_valid   (wb_valid),
    .wb_data    (wb_data),
    .wb_comp    (wb_comp),
    .wb_rd      (wb_rd),
    .wb_we      (wb_we)
  );

endmodule : ex_stage

// File: source/ex_writeback_reg.sv
`timescale 1ns/1ps

module ex_writeback_reg import ex_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     exec_valid,
  input  data_t    res,
  input  logic     comp_res,
  input  reg_idx_t exec_rd,
  output logic     wb_valid,
  output data_t    wb_data,
  output logic     wb_comp,
  output reg_idx_t wb_rd,
  output logic     wb_we
);

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_valid <= 1'b0;
      wb_we    <= 1'b0;
    end else begin
      wb_valid <= exec_valid;
      // x0 is hard-wired zero, drop the write here
      wb_we    <= exec_valid && (exec_rd != '0);
    end
  end

  ////////////////////////////////////////
  // Payload
  ////////////////////////////////////////

  // Held until the next valid item
  always_ff @(posedge clk) begin
    if (exec_valid) begin
      wb_data <= res;
      wb_comp <= comp_res;
      wb_rd   <= exec_rd;
    end
  end

endmodule : ex_writeback_reg

// File: source/alu.sv
`timescale 1ns/1ps

module alu import ex_pkg::*; (
  input  data_t   a,
  input  data_t   b,
  // PC of the instruction in execute
  input  data_t   pres_adr,
  input  alu_op_e alusel,
  input  logic    is_lui,
  input  logic    is_auipc,
  input  logic    is_jal,
  input  logic    is_jalr,
  input  logic    is_compare,
  input  key_t    key,
  output data_t   res,
  output logic    comp_res
);

  // Keyed functional unit result
  data_t s;

  // Unsigned less-than, always produced
  assign comp_res = (a < b);

  alu_chaos i_alu_chaos (
    .a      (a),
    .b      (b),
    .opcode (alusel),
    .key    (key),
    .y      (s)
  );

  ////////////////////////////////////////
  // Result select
  ////////////////////////////////////////

  // Priority LUI, AUIPC, JAL, JALR, compare, keyed result
  always_comb begin
    if (is_lui) begin
      res = b;
    end else if (is_auipc) begin
      // Only the low 12 PC bits enter the sum
      res = b + data_t'(pres_adr[11:0]);
    end else if (is_jal) begin
      // Link address
      res = pres_adr + data_t'(4);
    end else if (is_jalr) begin
      res = pres_adr;
    end else if (is_compare && comp_res) begin
      res = data_t'(1);
    end else begin
      // Compare false also falls through to here
      res = s;
    end
  end

endmodule : alu

// File: source/alu_chaos.sv
`timescale 1ns/1ps
`include "ex_config.svh"

module alu_chaos import ex_pkg::*; (
  input  data_t   a,
  input  data_t   b,
  input  alu_op_e opcode,
  input  key_t    key,
  output data_t   y
);

  // Key field layout
  localparam int op_field_w = `EX_OP_W;
  localparam int rot_lsb    = 24;
  localparam int rot_w      = $clog2(`EX_DATA_W);
  localparam int b_mask_lsb = 32;
  localparam int y_mask_lsb = 64;

  alu_op_e                 eff_op;
  logic [rot_w-1:0]        rot;
  logic [rot_w-1:0]        shamt;
  data_t                   b_mask;
  data_t                   y_mask;
  data_t                   b_eff;
  data_t                   raw;
  logic [2*`EX_DATA_W-1:0] rot_wide;

  ////////////////////////////////////////
  // Key decode
  ////////////////////////////////////////

  // Field n holds the op really run for requested op n
  assign eff_op = alu_op_e'(key[opcode*op_field_w +: op_field_w]);

  // Result rotation, bits 31:29 unused
  assign rot    = key[rot_lsb +: rot_w];

  // Data masks
  assign b_mask = key[b_mask_lsb +: `EX_DATA_W];
  assign y_mask = key[y_mask_lsb +: `EX_DATA_W];

  ////////////////////////////////////////
  // Operation
  ////////////////////////////////////////

  assign b_eff = b ^ b_mask;

  // Shifts take the low bits of the masked operand
  assign shamt = b_eff[rot_w-1:0];

  always_comb begin
    case (eff_op)
      op_add:  raw = a + b_eff;
      op_sub:  raw = a - b_eff;
      op_and:  raw = a & b_eff;
      op_or:   raw = a | b_eff;
      op_xor:  raw = a ^ b_eff;
      op_sll:  raw = a << shamt;
      op_srl:  raw = a >> shamt;
      // Arithmetic shift keeps the sign
      op_sra:  raw = $signed(a) >>> shamt;
      default: raw = a + b_eff;
    endcase
  end

  ////////////////////////////////////////
  // Output scrambling
  ////////////////////////////////////////

  // Rotate left via a doubled word, upper half is the result
  assign rot_wide = {raw, raw} << rot;

  assign y = rot_wide[2*`EX_DATA_W-1:`EX_DATA_W] ^ y_mask;

endmodule : alu_chaos

// File: source/ex_issue_reg.sv
`timescale 1ns/1ps

module ex_issue_reg import ex_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  // Issue side
  input  logic     issue_valid,
  input  data_t    op_a,
  input  data_t    op_b,
  input  data_t    pc,
  input  alu_op_e  alu_op,
  input  logic     is_lui,
  input  logic     is_auipc,
  input  logic     is_jal,
  input  logic     is_jalr,
  input  logic     is_compare,
  input  reg_idx_t rd,
  // Execute side
  output logic     exec_valid,
  output data_t    exec_a,
  output data_t    exec_b,
  output data_t    exec_pc,
  output alu_op_e  exec_op,
  output logic     exec_lui,
  output logic     exec_auipc,
  output logic     exec_jal,
  output logic     exec_jalr,
  output logic     exec_compare,
  output reg_idx_t exec_rd
);

  ////////////////////////////////////////
  // Valid bit
  ////////////////////////////////////////

  // High for exactly one cycle per issue strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      exec_valid <= 1'b0;
    end else begin
      exec_valid <= issue_valid;
    end
  end

  ////////////////////////////////////////
  // Payload
  ////////////////////////////////////////

  // Only meaningful while exec_valid is high
  always_ff @(posedge clk) begin
    if (issue_valid) begin
      exec_a       <= op_a;
      exec_b       <= op_b;
      exec_pc      <= pc;
      exec_op      <= alu_op;
      // Special-case flags from decode
      exec_lui     <= is_lui;
      exec_auipc   <= is_auipc;
      exec_jal     <= is_jal;
      exec_jalr    <= is_jalr;
      exec_compare <= is_compare;
      exec_rd      <= rd;
    end
  end

endmodule : ex_issue_reg

// File: source/key_store.sv
`timescale 1ns/1ps
`include "ex_config.svh"

module key_store import ex_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      key_load,
  input  key_word_t key_word,
  output key_t      key
);

  // Bits kept from the old key on each load
  localparam int keep_w = `EX_KEY_W - $bits(key_word_t);

  ////////////////////////////////////////
  // Key register
  ////////////////////////////////////////

  key_t key_q;

  // Zero key after reset
  // Every field maps to ADD, no rotation, no masks
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      key_q <= '0;
    end else if (key_load) begin
      // Older words move up, newest word enters at the bottom
      // First of three words ends in the top word
      key_q <= {key_q[keep_w-1:0], key_word};
    end
  end

  // Visible to the ALU the cycle after the strobe
  assign key = key_q;

endmodule : key_store

// File: source/ex_pkg.sv
`include "ex_config.svh"

package ex_pkg;

  ////////////////////////////////////////
  // Datapath types
  ////////////////////////////////////////

  // One data word of the core
  typedef logic [`EX_DATA_W-1:0] data_t;

  // Architectural register index, x0 to x31
  typedef logic [4:0] reg_idx_t;

  ////////////////////////////////////////
  // Key types
  ////////////////////////////////////////

  // Whole key as seen by the keyed ALU
  typedef logic [`EX_KEY_W-1:0] key_t;

  // One load word of the key
  typedef logic [`EX_KEY_W/`EX_KEY_WORDS-1:0] key_word_t;

  ////////////////////////////////////////
  // ALU operations
  ////////////////////////////////////////

  // Encoding matches the key field index
  typedef enum logic [`EX_OP_W-1:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_sll,
    op_srl,
    op_sra
  } alu_op_e;

endpackage : ex_pkg

// File: source/ex_config.svh
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// Datapath word width
`define EX_DATA_W 32

// Full ALU key, loaded as several data-sized words
`define EX_KEY_W 96
`define EX_KEY_WORDS 3

// Width of the ALU operation code
`define EX_OP_W 3

// Issue strobe to wb_valid, in clock cycles
`define EX_LATENCY 2

`endif
